/* mips_isa_pkg.sv */
//**************************************************************************
// MIPS32 instruction encoding: field widths, field types, major opcodes,
// SPECIAL/SPECIAL2 function codes and the CP0 CO-group function codes.
// Only the encodings handled by the decode stage are listed here.
// I-type opcodes other than the format-selecting ones are matched as
// literals inside the I-type decoder.
//**************************************************************************
package mips_isa_pkg;

    localparam int WORD_W    = 32;
    localparam int OPCODE_W  = 6;
    localparam int REG_IDX_W = 5;
    localparam int SHAMT_W   = 5;
    localparam int FUNCT_W   = 6;
    localparam int IMM_W     = 16;
    localparam int JIDX_W    = 26;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [OPCODE_W-1:0]  opcode_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [SHAMT_W-1:0]   shamt_t;
    typedef logic [FUNCT_W-1:0]   funct_t;
    typedef logic [IMM_W-1:0]     imm_t;
    typedef logic [JIDX_W-1:0]    jidx_t;

    // major opcodes that pick the format or a sub-decode
    localparam opcode_t OP_SPECIAL  = 6'h00;
    localparam opcode_t OP_REGIMM   = 6'h01;
    localparam opcode_t OP_J        = 6'h02;
    localparam opcode_t OP_JAL      = 6'h03;
    localparam opcode_t OP_COP0     = 6'h10;
    localparam opcode_t OP_SPECIAL2 = 6'h1c;

    // SPECIAL function field
    localparam funct_t FN_SLL     = 6'h00;
    localparam funct_t FN_SRL     = 6'h02;
    localparam funct_t FN_SRA     = 6'h03;
    localparam funct_t FN_SLLV    = 6'h04;
    localparam funct_t FN_SRLV    = 6'h06;
    localparam funct_t FN_SRAV    = 6'h07;
    localparam funct_t FN_JR      = 6'h08;
    localparam funct_t FN_JALR    = 6'h09;
    localparam funct_t FN_SYSCALL = 6'h0c;
    localparam funct_t FN_BREAK   = 6'h0d;
    localparam funct_t FN_MFHI    = 6'h10;
    localparam funct_t FN_MTHI    = 6'h11;
    localparam funct_t FN_MFLO    = 6'h12;
    localparam funct_t FN_MTLO    = 6'h13;
    localparam funct_t FN_MULT    = 6'h18;
    localparam funct_t FN_MULTU   = 6'h19;
    localparam funct_t FN_DIV     = 6'h1a;
    localparam funct_t FN_DIVU    = 6'h1b;
    localparam funct_t FN_ADD     = 6'h20;
    localparam funct_t FN_ADDU    = 6'h21;
    localparam funct_t FN_SUB     = 6'h22;
    localparam funct_t FN_SUBU    = 6'h23;
    localparam funct_t FN_AND     = 6'h24;
    localparam funct_t FN_OR      = 6'h25;
    localparam funct_t FN_XOR     = 6'h26;
    localparam funct_t FN_NOR     = 6'h27;
    localparam funct_t FN_SLT     = 6'h2a;
    localparam funct_t FN_SLTU    = 6'h2b;

    // SPECIAL2
    localparam funct_t FN2_MUL    = 6'h02;

    // COP0 with the CO bit set
    localparam funct_t CP0_TLBWI  = 6'h02;
    localparam funct_t CP0_TLBP   = 6'h08;
    localparam funct_t CP0_ERET   = 6'h18;
    localparam funct_t CP0_WAIT   = 6'h20;

endpackage

/* decode_pkg.sv */
//**************************************************************************
// Internal instruction codes produced by the decode stage.
// INST_INVALID must stay zero: it is the reset value of the decode
// output and the result for every unknown encoding.
//**************************************************************************
package decode_pkg;

    typedef logic [7:0] inst_t;

    localparam inst_t INST_INVALID = 8'd0;

    // SPECIAL R-type
    localparam inst_t INST_SLL     = 8'd1;
    localparam inst_t INST_SRL     = 8'd2;
    localparam inst_t INST_SRA     = 8'd3;
    localparam inst_t INST_SLLV    = 8'd4;
    localparam inst_t INST_SRLV    = 8'd5;
    localparam inst_t INST_SRAV    = 8'd6;
    localparam inst_t INST_JR      = 8'd7;
    localparam inst_t INST_JALR    = 8'd8;
    localparam inst_t INST_SYSCALL = 8'd9;
    localparam inst_t INST_BREAK   = 8'd10;
    localparam inst_t INST_MFHI    = 8'd11;
    localparam inst_t INST_MTHI    = 8'd12;
    localparam inst_t INST_MFLO    = 8'd13;
    localparam inst_t INST_MTLO    = 8'd14;
    localparam inst_t INST_MULT    = 8'd15;
    localparam inst_t INST_MULTU   = 8'd16;
    localparam inst_t INST_DIV     = 8'd17;
    localparam inst_t INST_DIVU    = 8'd18;
    localparam inst_t INST_ADD     = 8'd19;
    localparam inst_t INST_ADDU    = 8'd20;
    localparam inst_t INST_SUB     = 8'd21;
    localparam inst_t INST_SUBU    = 8'd22;
    localparam inst_t INST_AND     = 8'd23;
    localparam inst_t INST_OR      = 8'd24;
    localparam inst_t INST_XOR     = 8'd25;
    localparam inst_t INST_NOR     = 8'd26;
    localparam inst_t INST_SLT     = 8'd27;
    localparam inst_t INST_SLTU    = 8'd28;
    localparam inst_t INST_MUL     = 8'd29;

    // I-type branches and immediates
    localparam inst_t INST_BLTZ    = 8'd30;
    localparam inst_t INST_BGEZ    = 8'd31;
    localparam inst_t INST_BEQ     = 8'd32;
    localparam inst_t INST_BNE     = 8'd33;
    localparam inst_t INST_BLEZ    = 8'd34;
    localparam inst_t INST_BGTZ    = 8'd35;
    localparam inst_t INST_ADDIU   = 8'd36;
    localparam inst_t INST_SLTI    = 8'd37;
    localparam inst_t INST_SLTIU   = 8'd38;
    localparam inst_t INST_ANDI    = 8'd39;
    localparam inst_t INST_ORI     = 8'd40;
    localparam inst_t INST_XORI    = 8'd41;
    localparam inst_t INST_LUI     = 8'd42;

    // loads and stores
    localparam inst_t INST_LB      = 8'd43;
    localparam inst_t INST_LH      = 8'd44;
    localparam inst_t INST_LWL     = 8'd45;
    localparam inst_t INST_LW      = 8'd46;
    localparam inst_t INST_LBU     = 8'd47;
    localparam inst_t INST_LHU     = 8'd48;
    localparam inst_t INST_LWR     = 8'd49;
    localparam inst_t INST_SB      = 8'd50;
    localparam inst_t INST_SH      = 8'd51;
    localparam inst_t INST_SWL     = 8'd52;
    localparam inst_t INST_SW      = 8'd53;
    localparam inst_t INST_SWR     = 8'd54;

    // CP0 group
    localparam inst_t INST_MFC0    = 8'd55;
    localparam inst_t INST_MTC0    = 8'd56;
    localparam inst_t INST_TLBWI   = 8'd57;
    localparam inst_t INST_TLBP    = 8'd58;
    localparam inst_t INST_ERET    = 8'd59;
    localparam inst_t INST_WAIT    = 8'd60;

    // J-type
    localparam inst_t INST_J       = 8'd61;
    localparam inst_t INST_JAL     = 8'd62;

endpackage

/* id_i.sv */
//**************************************************************************
// Combinational I-type decoder, including REGIMM and the CP0 group.
// Opcodes it does not own (SPECIAL, SPECIAL2, J, JAL, unused) give
// INST_INVALID. Register fields are not checked beyond what selects
// the instruction.
//**************************************************************************
`timescale 1ns/1ps

module id_i
(
    input  mips_isa_pkg::word_t inst_code,
    output decode_pkg::inst_t   inst
);

    mips_isa_pkg::opcode_t  opcode;
    mips_isa_pkg::reg_idx_t rs;
    mips_isa_pkg::reg_idx_t rt;
    mips_isa_pkg::funct_t   funct;

    assign opcode = inst_code[31:26];
    assign rs     = inst_code[25:21];
    assign rt     = inst_code[20:16];
    assign funct  = inst_code[5:0];

    always_comb
    begin
        case (opcode)
            mips_isa_pkg::OP_REGIMM:
            begin
                // branch kind sits in rt
                case (rt)
                    5'h00:   inst = decode_pkg::INST_BLTZ;
                    5'h01:   inst = decode_pkg::INST_BGEZ;
                    default: inst = decode_pkg::INST_INVALID;
                endcase
            end
            6'h04: inst = decode_pkg::INST_BEQ;
            6'h05: inst = decode_pkg::INST_BNE;
            6'h06: inst = decode_pkg::INST_BLEZ;
            6'h07: inst = decode_pkg::INST_BGTZ;
            6'h09: inst = decode_pkg::INST_ADDIU;
            6'h0a: inst = decode_pkg::INST_SLTI;
            6'h0b: inst = decode_pkg::INST_SLTIU;
            6'h0c: inst = decode_pkg::INST_ANDI;
            6'h0d: inst = decode_pkg::INST_ORI;
            6'h0e: inst = decode_pkg::INST_XORI;
            6'h0f: inst = decode_pkg::INST_LUI;
            mips_isa_pkg::OP_COP0:
            begin
                if (rs == 5'h00)
                    inst = decode_pkg::INST_MFC0;
                else if (rs == 5'h04)
                    inst = decode_pkg::INST_MTC0;
                else if (rs[4])
                begin
                    // CO bit set, operation in the function field
                    case (funct)
                        mips_isa_pkg::CP0_TLBWI: inst = decode_pkg::INST_TLBWI;
                        mips_isa_pkg::CP0_TLBP:  inst = decode_pkg::INST_TLBP;
                        mips_isa_pkg::CP0_ERET:  inst = decode_pkg::INST_ERET;
                        mips_isa_pkg::CP0_WAIT:  inst = decode_pkg::INST_WAIT;
                        default:                 inst = decode_pkg::INST_INVALID;
                    endcase
                end
                else
                    inst = decode_pkg::INST_INVALID;
            end
            6'h20: inst = decode_pkg::INST_LB;
            6'h21: inst = decode_pkg::INST_LH;
            6'h22: inst = decode_pkg::INST_LWL;
            6'h23: inst = decode_pkg::INST_LW;
            6'h24: inst = decode_pkg::INST_LBU;
            6'h25: inst = decode_pkg::INST_LHU;
            6'h26: inst = decode_pkg::INST_LWR;
            6'h28: inst = decode_pkg::INST_SB;
            6'h29: inst = decode_pkg::INST_SH;
            6'h2a: inst = decode_pkg::INST_SWL;
            6'h2b: inst = decode_pkg::INST_SW;
            6'h2e: inst = decode_pkg::INST_SWR;
            default: inst = decode_pkg::INST_INVALID;
        endcase
    end

endmodule

/* id_r.sv */
//**************************************************************************
// Combinational R-type decoder for SPECIAL and SPECIAL2 (MUL only).
// Any other opcode, or an unlisted function code, gives INST_INVALID.
// The shamt and unused register fields are not checked for zero.
//**************************************************************************
`timescale 1ns/1ps

module id_r
(
    input  mips_isa_pkg::word_t    inst_code,
    output decode_pkg::inst_t      inst,
    output mips_isa_pkg::reg_idx_t reg_d
);

    mips_isa_pkg::opcode_t opcode;
    mips_isa_pkg::funct_t  funct;

    assign opcode = inst_code[31:26];
    assign funct  = inst_code[5:0];
    assign reg_d  = inst_code[15:11];

    always_comb
    begin
        inst = decode_pkg::INST_INVALID;
        if (opcode == mips_isa_pkg::OP_SPECIAL)
        begin
            case (funct)
                mips_isa_pkg::FN_SLL:     inst = decode_pkg::INST_SLL;
                mips_isa_pkg::FN_SRL:     inst = decode_pkg::INST_SRL;
                mips_isa_pkg::FN_SRA:     inst = decode_pkg::INST_SRA;
                mips_isa_pkg::FN_SLLV:    inst = decode_pkg::INST_SLLV;
                mips_isa_pkg::FN_SRLV:    inst = decode_pkg::INST_SRLV;
                mips_isa_pkg::FN_SRAV:    inst = decode_pkg::INST_SRAV;
                mips_isa_pkg::FN_JR:      inst = decode_pkg::INST_JR;
                mips_isa_pkg::FN_JALR:    inst = decode_pkg::INST_JALR;
                mips_isa_pkg::FN_SYSCALL: inst = decode_pkg::INST_SYSCALL;
                mips_isa_pkg::FN_BREAK:   inst = decode_pkg::INST_BREAK;
                mips_isa_pkg::FN_MFHI:    inst = decode_pkg::INST_MFHI;
                mips_isa_pkg::FN_MTHI:    inst = decode_pkg::INST_MTHI;
                mips_isa_pkg::FN_MFLO:    inst = decode_pkg::INST_MFLO;
                mips_isa_pkg::FN_MTLO:    inst = decode_pkg::INST_MTLO;
                mips_isa_pkg::FN_MULT:    inst = decode_pkg::INST_MULT;
                mips_isa_pkg::FN_MULTU:   inst = decode_pkg::INST_MULTU;
                mips_isa_pkg::FN_DIV:     inst = decode_pkg::INST_DIV;
                mips_isa_pkg::FN_DIVU:    inst = decode_pkg::INST_DIVU;
                mips_isa_pkg::FN_ADD:     inst = decode_pkg::INST_ADD;
                mips_isa_pkg::FN_ADDU:    inst = decode_pkg::INST_ADDU;
                mips_isa_pkg::FN_SUB:     inst = decode_pkg::INST_SUB;
                mips_isa_pkg::FN_SUBU:    inst = decode_pkg::INST_SUBU;
                mips_isa_pkg::FN_AND:     inst = decode_pkg::INST_AND;
                mips_isa_pkg::FN_OR:      inst = decode_pkg::INST_OR;
                mips_isa_pkg::FN_XOR:     inst = decode_pkg::INST_XOR;
                mips_isa_pkg::FN_NOR:     inst = decode_pkg::INST_NOR;
                mips_isa_pkg::FN_SLT:     inst = decode_pkg::INST_SLT;
                mips_isa_pkg::FN_SLTU:    inst = decode_pkg::INST_SLTU;
                default:                  inst = decode_pkg::INST_INVALID;
            endcase
        end
        else if (opcode == mips_isa_pkg::OP_SPECIAL2)
        begin
            // only MUL is supported from SPECIAL2
            if (funct == mips_isa_pkg::FN2_MUL)
                inst = decode_pkg::INST_MUL;
        end
    end

endmodule

/* id_stage.sv */
//**************************************************************************
// Instruction decode stage: one word in per clock, registered decode out
// exactly one cycle later. No back-pressure; the consumer must take the
// result in its dec_valid cycle. With inst_valid low the outputs other
// than dec_valid hold their last value. Reset is synchronous.
//**************************************************************************
`timescale 1ns/1ps

module id_stage
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   inst_valid,
    input  mips_isa_pkg::word_t    inst_code,
    output logic                   dec_valid,
    output decode_pkg::inst_t      inst,
    output mips_isa_pkg::reg_idx_t reg_s,
    output mips_isa_pkg::reg_idx_t reg_t,
    output mips_isa_pkg::reg_idx_t reg_d,
    output mips_isa_pkg::shamt_t   shamt,
    output mips_isa_pkg::word_t    imm_ext,
    output mips_isa_pkg::jidx_t    jump_index
);

    mips_isa_pkg::opcode_t  opcode;
    mips_isa_pkg::imm_t     imm;
    mips_isa_pkg::reg_idx_t r_reg_d;
    mips_isa_pkg::word_t    imm_ext_d;
    decode_pkg::inst_t      i_inst;
    decode_pkg::inst_t      r_inst;
    decode_pkg::inst_t      sel_inst;

    assign opcode = inst_code[31:26];
    assign imm    = inst_code[15:0];

    id_i u_id_i
    (
        .inst_code (inst_code),
        .inst      (i_inst)
    );

    id_r u_id_r
    (
        .inst_code (inst_code),
        .inst      (r_inst),
        .reg_d     (r_reg_d)
    );

    // format select, jumps decoded here
    always_comb
    begin
        case (opcode)
            mips_isa_pkg::OP_SPECIAL,
            mips_isa_pkg::OP_SPECIAL2: sel_inst = r_inst;
            mips_isa_pkg::OP_J:        sel_inst = decode_pkg::INST_J;
            mips_isa_pkg::OP_JAL:      sel_inst = decode_pkg::INST_JAL;
            default:                   sel_inst = i_inst;
        endcase
    end

    // logic ops zero-extend, LUI shifts up, the rest sign-extend
    always_comb
    begin
        case (sel_inst)
            decode_pkg::INST_ANDI,
            decode_pkg::INST_ORI,
            decode_pkg::INST_XORI: imm_ext_d = {16'h0000, imm};
            decode_pkg::INST_LUI:  imm_ext_d = {imm, 16'h0000};
            default:               imm_ext_d = {{16{imm[15]}}, imm};
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            dec_valid  <= 1'b0;
            inst       <= decode_pkg::INST_INVALID;
            reg_s      <= '0;
            reg_t      <= '0;
            reg_d      <= '0;
            shamt      <= '0;
            imm_ext    <= '0;
            jump_index <= '0;
        end
        else
        begin
            dec_valid <= inst_valid;
            if (inst_valid)
            begin
                inst       <= sel_inst;
                reg_s      <= inst_code[25:21];
                reg_t      <= inst_code[20:16];
                reg_d      <= r_reg_d;
                shamt      <= inst_code[10:6];
                imm_ext    <= imm_ext_d;
                jump_index <= inst_code[25:0];
            end
        end
    end

endmodule

/* id_stage_props.sv */
//**************************************************************************
// Concurrent checks bound to every id_stage instance, sampled on the
// rising clock edge. Covers the valid timing and the upper half of the
// zero-extended immediates only.
//**************************************************************************
`timescale 1ns/1ps

module id_stage_props
(
    input logic                clk,
    input logic                rst,
    input logic                inst_valid,
    input logic                dec_valid,
    input decode_pkg::inst_t   inst,
    input mips_isa_pkg::word_t imm_ext
);

    // one cycle of latency, nothing added or dropped
    valid_follows_input: assert property (@(posedge clk)
        !rst |=> dec_valid == $past(inst_valid))
        else $error("dec_valid does not match inst_valid of the previous cycle");

    valid_low_after_reset: assert property (@(posedge clk) rst |=> !dec_valid)
        else $error("dec_valid is high in the cycle after reset");

    logic_imm_zero_ext: assert property (@(posedge clk)
        dec_valid && (inst == decode_pkg::INST_ANDI || inst == decode_pkg::INST_ORI ||
                      inst == decode_pkg::INST_XORI) |-> imm_ext[31:16] == 16'h0000)
        else $error("logic immediate has nonzero upper half");

endmodule

bind id_stage id_stage_props u_props
(
    .clk        (clk),
    .rst        (rst),
    .inst_valid (inst_valid),
    .dec_valid  (dec_valid),
    .inst       (inst),
    .imm_ext    (imm_ext)
);

/* tb_id_stage.sv */
//**************************************************************************
// Directed testbench for id_stage. Inputs change on the falling edge and
// outputs are sampled there too. Expected codes come from opcode and
// function tables taken from the MIPS32 opcode map. Random fields come
// from a fixed-seed xorshift, so every run applies the same words.
//**************************************************************************
`timescale 1ns/1ps

module tb_id_stage;

    logic                   clk;
    logic                   rst;
    logic                   inst_valid;
    mips_isa_pkg::word_t    inst_code;
    logic                   dec_valid;
    decode_pkg::inst_t      inst;
    mips_isa_pkg::reg_idx_t reg_s;
    mips_isa_pkg::reg_idx_t reg_t;
    mips_isa_pkg::reg_idx_t reg_d;
    mips_isa_pkg::shamt_t   shamt;
    mips_isa_pkg::word_t    imm_ext;
    mips_isa_pkg::jidx_t    jump_index;

    int          errors;
    int          checks;
    logic [31:0] rng_state;

    // entries are {opcode or funct, expected code}
    logic [13:0] i_table [$];
    logic [13:0] r_table [$];

    id_stage dut0
    (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst_code  (inst_code),
        .dec_valid  (dec_valid),
        .inst       (inst),
        .reg_s      (reg_s),
        .reg_t      (reg_t),
        .reg_d      (reg_d),
        .shamt      (shamt),
        .imm_ext    (imm_ext),
        .jump_index (jump_index)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic mips_isa_pkg::word_t extend_imm(input decode_pkg::inst_t code,
                                                      input mips_isa_pkg::imm_t imm);
        if (code == decode_pkg::INST_ANDI || code == decode_pkg::INST_ORI ||
            code == decode_pkg::INST_XORI)
            return {16'h0000, imm};
        else if (code == decode_pkg::INST_LUI)
            return {imm, 16'h0000};
        else
            return {{16{imm[15]}}, imm};
    endfunction

    task automatic check_value(input string name, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("[ERROR] %s %s: expected %h, actual %h", name, field, exp, act);
        end
    endtask

    // every output field follows from the word and the expected code
    task automatic check_outputs(input string name, input mips_isa_pkg::word_t w,
                                 input decode_pkg::inst_t exp);
        check_value(name, "inst", exp, inst);
        check_value(name, "reg_s", w[25:21], reg_s);
        check_value(name, "reg_t", w[20:16], reg_t);
        check_value(name, "reg_d", w[15:11], reg_d);
        check_value(name, "shamt", w[10:6], shamt);
        check_value(name, "imm_ext", extend_imm(exp, w[15:0]), imm_ext);
        check_value(name, "jump_index", w[25:0], jump_index);
    endtask

    task automatic send_word(input string name, input mips_isa_pkg::word_t w,
                             input decode_pkg::inst_t exp);
        int waited;
        inst_valid = 1'b1;
        inst_code  = w;
        @(negedge clk);
        inst_valid = 1'b0;
        waited = 0;
        while (!dec_valid && waited < 10)
        begin
            @(negedge clk);
            waited++;
        end
        if (!dec_valid)
        begin
            $display("%s: dec_valid did not rise within 10 cycles", name);
            $display("=== FAIL ===");
            $finish;
        end
        else
            check_outputs(name, w, exp);
    endtask

    task automatic reset_behavior();
        // a valid word during reset must not get through
        rst        = 1'b1;
        inst_valid = 1'b1;
        inst_code  = 32'h2408_1234;
        repeat (2) @(negedge clk);
        check_value("reset", "dec_valid", 1'b0, dec_valid);
        check_value("reset", "inst", decode_pkg::INST_INVALID, inst);
        rst        = 1'b0;
        inst_valid = 1'b0;
        @(negedge clk);
        check_value("after_reset", "dec_valid", 1'b0, dec_valid);
        check_value("after_reset", "inst", decode_pkg::INST_INVALID, inst);
        check_value("after_reset", "imm_ext", 32'h0, imm_ext);
    endtask

    // immediates, branches, loads and stores, each with imm[15] set and clear
    task automatic immediate_and_memory();
        logic [13:0]         entry;
        logic [31:0]         rnd;
        mips_isa_pkg::word_t w;
        for (int k = 0; k < i_table.size(); k++)
        begin
            entry = i_table[k];
            rnd   = next_random();
            w     = {entry[13:8], rnd[25:16], 1'b1, rnd[14:0]};
            send_word($sformatf("itype_op%02h_neg", entry[13:8]), w, entry[7:0]);
            w[15] = 1'b0;
            send_word($sformatf("itype_op%02h_pos", entry[13:8]), w, entry[7:0]);
        end
    endtask

    task automatic regimm_and_cp0();
        logic [31:0] rnd;
        rnd = next_random();
        send_word("bltz", {6'h01, rnd[25:21], 5'h00, rnd[15:0]}, decode_pkg::INST_BLTZ);
        send_word("bgez", {6'h01, rnd[25:21], 5'h01, rnd[15:0]}, decode_pkg::INST_BGEZ);
        send_word("regimm_bad_rt", {6'h01, rnd[25:21], 5'h02, rnd[15:0]},
                  decode_pkg::INST_INVALID);
        send_word("mfc0", {6'h10, 5'h00, rnd[20:0]}, decode_pkg::INST_MFC0);
        send_word("mtc0", {6'h10, 5'h04, rnd[20:0]}, decode_pkg::INST_MTC0);
        send_word("tlbwi", 32'h4200_0002, decode_pkg::INST_TLBWI);
        send_word("tlbp", 32'h4200_0008, decode_pkg::INST_TLBP);
        send_word("eret", 32'h4200_0018, decode_pkg::INST_ERET);
        send_word("wait", 32'h4200_0020, decode_pkg::INST_WAIT);
        send_word("cop0_bad_co_fn", 32'h4200_0001, decode_pkg::INST_INVALID);
        send_word("cop0_bad_rs", {6'h10, 5'h01, rnd[20:0]}, decode_pkg::INST_INVALID);
    endtask

    task automatic rtype_functions();
        logic [13:0] entry;
        logic [31:0] rnd;
        for (int k = 0; k < r_table.size(); k++)
        begin
            entry = r_table[k];
            rnd   = next_random();
            send_word($sformatf("rtype_fn%02h", entry[13:8]),
                      {6'h00, rnd[25:6], entry[13:8]}, entry[7:0]);
        end
        rnd = next_random();
        send_word("mul", {6'h1c, rnd[25:6], 6'h02}, decode_pkg::INST_MUL);
        send_word("special_bad_fn", {6'h00, rnd[25:6], 6'h01}, decode_pkg::INST_INVALID);
        send_word("special2_bad_fn", {6'h1c, rnd[25:6], 6'h20}, decode_pkg::INST_INVALID);
    endtask

    task automatic jumps_and_bad_opcodes();
        logic [31:0] rnd;
        rnd = next_random();
        send_word("j", {6'h02, rnd[25:0]}, decode_pkg::INST_J);
        rnd = next_random();
        send_word("jal", {6'h03, rnd[25:0]}, decode_pkg::INST_JAL);
        send_word("bad_op_3f", {6'h3f, rnd[25:0]}, decode_pkg::INST_INVALID);
        send_word("bad_op_3b", {6'h3b, rnd[25:0]}, decode_pkg::INST_INVALID);
    endtask

    // one word per clock, each result due exactly one cycle later
    task automatic back_to_back_stream();
        mips_isa_pkg::word_t words [4];
        decode_pkg::inst_t   codes [4];
        logic [31:0]         rnd;
        rnd      = next_random();
        words[0] = {6'h00, rnd[25:6], 6'h21};
        codes[0] = decode_pkg::INST_ADDU;
        words[1] = {6'h0f, rnd[31:6]};
        codes[1] = decode_pkg::INST_LUI;
        words[2] = {6'h02, rnd[27:2]};
        codes[2] = decode_pkg::INST_J;
        words[3] = {6'h0d, rnd[29:4]};
        codes[3] = decode_pkg::INST_ORI;
        inst_valid = 1'b1;
        inst_code  = words[0];
        for (int k = 0; k < 4; k++)
        begin
            @(negedge clk);
            if (k < 3)
                inst_code = words[k + 1];
            else
            begin
                // a different word with valid low must not load
                inst_valid = 1'b0;
                inst_code  = ~words[3];
            end
            check_value("stream", "dec_valid", 1'b1, dec_valid);
            check_outputs($sformatf("stream_%0d", k), words[k], codes[k]);
        end
        @(negedge clk);
        check_value("stream_idle", "dec_valid", 1'b0, dec_valid);
        check_outputs("stream_idle", words[3], codes[3]);
    endtask

    initial
    begin
        errors     = 0;
        checks     = 0;
        rng_state  = 32'hfe8c_ddcc;
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst_code  = '0;
        i_table = '{
            {6'h04, decode_pkg::INST_BEQ},   {6'h05, decode_pkg::INST_BNE},
            {6'h06, decode_pkg::INST_BLEZ},  {6'h07, decode_pkg::INST_BGTZ},
            {6'h09, decode_pkg::INST_ADDIU}, {6'h0a, decode_pkg::INST_SLTI},
            {6'h0b, decode_pkg::INST_SLTIU}, {6'h0c, decode_pkg::INST_ANDI},
            {6'h0d, decode_pkg::INST_ORI},   {6'h0e, decode_pkg::INST_XORI},
            {6'h0f, decode_pkg::INST_LUI},   {6'h20, decode_pkg::INST_LB},
            {6'h21, decode_pkg::INST_LH},    {6'h22, decode_pkg::INST_LWL},
            {6'h23, decode_pkg::INST_LW},    {6'h24, decode_pkg::INST_LBU},
            {6'h25, decode_pkg::INST_LHU},   {6'h26, decode_pkg::INST_LWR},
            {6'h28, decode_pkg::INST_SB},    {6'h29, decode_pkg::INST_SH},
            {6'h2a, decode_pkg::INST_SWL},   {6'h2b, decode_pkg::INST_SW},
            {6'h2e, decode_pkg::INST_SWR}};
        r_table = '{
            {6'h00, decode_pkg::INST_SLL},   {6'h02, decode_pkg::INST_SRL},
            {6'h03, decode_pkg::INST_SRA},   {6'h04, decode_pkg::INST_SLLV},
            {6'h06, decode_pkg::INST_SRLV},  {6'h07, decode_pkg::INST_SRAV},
            {6'h08, decode_pkg::INST_JR},    {6'h09, decode_pkg::INST_JALR},
            {6'h0c, decode_pkg::INST_SYSCALL}, {6'h0d, decode_pkg::INST_BREAK},
            {6'h10, decode_pkg::INST_MFHI},  {6'h11, decode_pkg::INST_MTHI},
            {6'h12, decode_pkg::INST_MFLO},  {6'h13, decode_pkg::INST_MTLO},
            {6'h18, decode_pkg::INST_MULT},  {6'h19, decode_pkg::INST_MULTU},
            {6'h1a, decode_pkg::INST_DIV},   {6'h1b, decode_pkg::INST_DIVU},
            {6'h20, decode_pkg::INST_ADD},   {6'h21, decode_pkg::INST_ADDU},
            {6'h22, decode_pkg::INST_SUB},   {6'h23, decode_pkg::INST_SUBU},
            {6'h24, decode_pkg::INST_AND},   {6'h25, decode_pkg::INST_OR},
            {6'h26, decode_pkg::INST_XOR},   {6'h27, decode_pkg::INST_NOR},
            {6'h2a, decode_pkg::INST_SLT},   {6'h2b, decode_pkg::INST_SLTU}};
        reset_behavior();
        immediate_and_memory();
        regimm_and_cp0();
        rtype_functions();
        jumps_and_bad_opcodes();
        back_to_back_stream();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

/* all.f */
mips_isa_pkg.sv
decode_pkg.sv
id_i.sv
id_r.sv
id_stage.sv
id_stage_props.sv
tb_id_stage.sv

/* Bender.yml */
package:
  name: mips_id_stage

sources:
  - mips_isa_pkg.sv
  - decode_pkg.sv
  - id_i.sv
  - id_r.sv
  - id_stage.sv
  - target: test
    files:
      - id_stage_props.sv
      - tb_id_stage.sv
